// File: Bender.yml
package:
  name: bypass

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/bypass_pkg.sv
      - hw/bypass_track.sv
      - hw/forward_ctrl.sv
      - hw/bypass_mux.sv
      - hw/bypass_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/bypass_assert.sv
      - verification/bypass_tb.sv

// File: bypass.f
+incdir+hw
hw/bypass_pkg.sv
hw/bypass_track.sv
hw/forward_ctrl.sv
hw/bypass_mux.sv
hw/bypass_top.sv
verification/bypass_assert.sv
verification/bypass_tb.sv

// File: hw/bypass_defs.svh
`ifndef BYPASS_DEFS_SVH
`define BYPASS_DEFS_SVH

// register number width.
`define BYPASS_REG_W 5

// datapath width for alu results, hi/lo and load data.
`define BYPASS_DATA_W 32

// width of the rs/rt forward select code.
`define BYPASS_SEL_W 3

`endif

// File: hw/bypass_mux.sv
`timescale 1ns/1ps

`include "bypass_defs.svh"

module bypass_mux (
    input  bypass_pkg::fwd_sel_t      fwd_sel,
    input  bypass_pkg::slot_info_t    ex_slot_1,
    input  bypass_pkg::slot_info_t    ex_slot_2,
    input  bypass_pkg::slot_info_t    mem_slot_1,
    input  bypass_pkg::slot_info_t    mem_slot_2,
    input  logic [`BYPASS_DATA_W-1:0] mem_load_data_1,
    input  logic [`BYPASS_DATA_W-1:0] mem_load_data_2,
    input  logic [`BYPASS_DATA_W-1:0] rf_rs_data,
    input  logic [`BYPASS_DATA_W-1:0] rf_rt_data,
    input  logic [`BYPASS_DATA_W-1:0] rf_hi,
    input  logic [`BYPASS_DATA_W-1:0] rf_lo,
    output logic [`BYPASS_DATA_W-1:0] rs_data,
    output logic [`BYPASS_DATA_W-1:0] rt_data,
    output logic [`BYPASS_DATA_W-1:0] hi_data,
    output logic [`BYPASS_DATA_W-1:0] lo_data
);

    import bypass_pkg::*;

    // seven-way operand choice.
    function automatic logic [`BYPASS_DATA_W-1:0] pick_operand(
        input fwd_sel_e                  sel,
        input logic [`BYPASS_DATA_W-1:0] rf_data
    );
        case (sel)
            FWD_EXP_ALU:  pick_operand = ex_slot_2.alu_res;
            FWD_EXC_ALU:  pick_operand = ex_slot_1.alu_res;
            FWD_MEMP_MEM: pick_operand = mem_load_data_2;
            FWD_MEMP_ALU: pick_operand = mem_slot_2.alu_res;
            FWD_MEMC_MEM: pick_operand = mem_load_data_1;
            FWD_MEMC_ALU: pick_operand = mem_slot_1.alu_res;
            default:      pick_operand = rf_data;
        endcase
    endfunction

    // three-way hi/lo choice.
    function automatic logic [`BYPASS_DATA_W-1:0] pick_half(
        input hilo_sel_e                 sel,
        input logic [`BYPASS_DATA_W-1:0] memp_val,
        input logic [`BYPASS_DATA_W-1:0] memc_val,
        input logic [`BYPASS_DATA_W-1:0] rf_val
    );
        case (sel)
            HILO_MEMP: pick_half = memp_val;
            HILO_MEMC: pick_half = memc_val;
            default:   pick_half = rf_val;
        endcase
    endfunction

    always_comb begin
        rs_data = pick_operand(fwd_sel.rs, rf_rs_data);
        rt_data = pick_operand(fwd_sel.rt, rf_rt_data);
        hi_data = pick_half(fwd_sel.hi, mem_slot_2.hi, mem_slot_1.hi, rf_hi);
        lo_data = pick_half(fwd_sel.lo, mem_slot_2.lo, mem_slot_1.lo, rf_lo);
    end

endmodule

// File: hw/bypass_pkg.sv
`include "bypass_defs.svh"

package bypass_pkg;

    // ==================================================
    // select codes
    // ==================================================

    // source of an rs or rt operand.
    typedef enum logic [`BYPASS_SEL_W-1:0] {
        FWD_NOP      = 3'd0,
        FWD_EXP_ALU  = 3'd1,
        FWD_EXC_ALU  = 3'd2,
        FWD_MEMP_MEM = 3'd3,
        FWD_MEMP_ALU = 3'd4,
        FWD_MEMC_MEM = 3'd5,
        FWD_MEMC_ALU = 3'd6
    } fwd_sel_e;

    // source of the hi or lo half.
    typedef enum logic [1:0] {
        HILO_NOP  = 2'd0,
        HILO_MEMP = 2'd1,
        HILO_MEMC = 2'd2
    } hilo_sel_e;

    // ==================================================
    // in-flight instruction info
    // ==================================================

    typedef struct packed {
        logic                      w_reg_ena;
        logic [`BYPASS_REG_W-1:0]  w_reg_dst;
        logic                      ls_ena;
        logic [1:0]                w_hilo_ena;   // [1] hi, [0] lo.
        logic [`BYPASS_DATA_W-1:0] alu_res;
        logic [`BYPASS_DATA_W-1:0] hi;
        logic [`BYPASS_DATA_W-1:0] lo;
    } slot_info_t;

    // all four selects, control to mux.
    typedef struct packed {
        fwd_sel_e  rs;
        fwd_sel_e  rt;
        hilo_sel_e hi;
        hilo_sel_e lo;
    } fwd_sel_t;

endpackage

// File: hw/bypass_top.sv
`timescale 1ns/1ps

`include "bypass_defs.svh"

module bypass_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [`BYPASS_REG_W-1:0]  id_rs,
    input  logic [`BYPASS_REG_W-1:0]  id_rt,
    input  bypass_pkg::slot_info_t    ex_slot_1,
    input  bypass_pkg::slot_info_t    ex_slot_2,
    input  logic [`BYPASS_DATA_W-1:0] mem_load_data_1,
    input  logic [`BYPASS_DATA_W-1:0] mem_load_data_2,
    input  logic [`BYPASS_DATA_W-1:0] rf_rs_data,
    input  logic [`BYPASS_DATA_W-1:0] rf_rt_data,
    input  logic [`BYPASS_DATA_W-1:0] rf_hi,
    input  logic [`BYPASS_DATA_W-1:0] rf_lo,
    output logic [`BYPASS_DATA_W-1:0] rs_data,
    output logic [`BYPASS_DATA_W-1:0] rt_data,
    output logic [`BYPASS_DATA_W-1:0] hi_data,
    output logic [`BYPASS_DATA_W-1:0] lo_data,
    output logic                      stall_req,
    output logic                      flush_req
);

    import bypass_pkg::*;

    slot_info_t mem_slot_1;
    slot_info_t mem_slot_2;
    fwd_sel_t   fwd_sel;

    // ex to mem stage registers.
    bypass_track u_bypass_track (
        .clk        (clk),
        .arst_n     (arst_n),
        .ex_slot_1  (ex_slot_1),
        .ex_slot_2  (ex_slot_2),
        .mem_slot_1 (mem_slot_1),
        .mem_slot_2 (mem_slot_2)
    );

    forward_ctrl u_forward_ctrl (
        .id_rs      (id_rs),
        .id_rt      (id_rt),
        .ex_slot_1  (ex_slot_1),
        .ex_slot_2  (ex_slot_2),
        .mem_slot_1 (mem_slot_1),
        .mem_slot_2 (mem_slot_2),
        .fwd_sel    (fwd_sel),
        .stall_req  (stall_req),
        .flush_req  (flush_req)
    );

    bypass_mux u_bypass_mux (
        .fwd_sel         (fwd_sel),
        .ex_slot_1       (ex_slot_1),
        .ex_slot_2       (ex_slot_2),
        .mem_slot_1      (mem_slot_1),
        .mem_slot_2      (mem_slot_2),
        .mem_load_data_1 (mem_load_data_1),
        .mem_load_data_2 (mem_load_data_2),
        .rf_rs_data      (rf_rs_data),
        .rf_rt_data      (rf_rt_data),
        .rf_hi           (rf_hi),
        .rf_lo           (rf_lo),
        .rs_data         (rs_data),
        .rt_data         (rt_data),
        .hi_data         (hi_data),
        .lo_data         (lo_data)
    );

endmodule

// File: hw/bypass_track.sv
`timescale 1ns/1ps

`include "bypass_defs.svh"

module bypass_track (
    input  logic                   clk,
    input  logic                   arst_n,
    input  bypass_pkg::slot_info_t ex_slot_1,
    input  bypass_pkg::slot_info_t ex_slot_2,
    output bypass_pkg::slot_info_t mem_slot_1,
    output bypass_pkg::slot_info_t mem_slot_2
);

    import bypass_pkg::*;

    // index 0 is slot 1, index 1 is slot 2.
    slot_info_t                ex_slot [2];
    logic [1:0]                w_reg_ena_q;
    logic [1:0]                ls_ena_q;
    logic [1:0]                w_hilo_ena_q [2];
    logic [`BYPASS_REG_W-1:0]  w_reg_dst_q [2];
    logic [`BYPASS_DATA_W-1:0] alu_res_q [2];
    logic [`BYPASS_DATA_W-1:0] hi_q [2];
    logic [`BYPASS_DATA_W-1:0] lo_q [2];

    assign ex_slot[0] = ex_slot_1;
    assign ex_slot[1] = ex_slot_2;

    // control bits of the ex/mem register.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            w_reg_ena_q  <= '0;
            ls_ena_q     <= '0;
            w_hilo_ena_q <= '{default: '0};
        end else begin
            for (int i = 0; i < 2; i++) begin
                w_reg_ena_q[i]  <= ex_slot[i].w_reg_ena;
                ls_ena_q[i]     <= ex_slot[i].ls_ena;
                w_hilo_ena_q[i] <= ex_slot[i].w_hilo_ena;
            end
        end
    end

    // payload.
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            w_reg_dst_q[i] <= ex_slot[i].w_reg_dst;
            alu_res_q[i]   <= ex_slot[i].alu_res;
            hi_q[i]        <= ex_slot[i].hi;
            lo_q[i]        <= ex_slot[i].lo;
        end
    end

    always_comb begin
        mem_slot_1.w_reg_ena  = w_reg_ena_q[0];
        mem_slot_1.w_reg_dst  = w_reg_dst_q[0];
        mem_slot_1.ls_ena     = ls_ena_q[0];
        mem_slot_1.w_hilo_ena = w_hilo_ena_q[0];
        mem_slot_1.alu_res    = alu_res_q[0];
        mem_slot_1.hi         = hi_q[0];
        mem_slot_1.lo         = lo_q[0];

        mem_slot_2.w_reg_ena  = w_reg_ena_q[1];
        mem_slot_2.w_reg_dst  = w_reg_dst_q[1];
        mem_slot_2.ls_ena     = ls_ena_q[1];
        mem_slot_2.w_hilo_ena = w_hilo_ena_q[1];
        mem_slot_2.alu_res    = alu_res_q[1];
        mem_slot_2.hi         = hi_q[1];
        mem_slot_2.lo         = lo_q[1];
    end

endmodule

// File: hw/forward_ctrl.sv
`timescale 1ns/1ps

`include "bypass_defs.svh"

module forward_ctrl (
    input  logic [`BYPASS_REG_W-1:0] id_rs,
    input  logic [`BYPASS_REG_W-1:0] id_rt,
    input  bypass_pkg::slot_info_t   ex_slot_1,
    input  bypass_pkg::slot_info_t   ex_slot_2,
    input  bypass_pkg::slot_info_t   mem_slot_1,
    input  bypass_pkg::slot_info_t   mem_slot_2,
    output bypass_pkg::fwd_sel_t     fwd_sel,
    output logic                     stall_req,
    output logic                     flush_req
);

    import bypass_pkg::*;

    logic ex_load_hit_1;
    logic ex_load_hit_2;

    // ==================================================
    // register write match
    // ==================================================

    function automatic logic reg_hit(
        input logic [`BYPASS_REG_W-1:0] src,
        input slot_info_t               slot
    );
        reg_hit = slot.w_reg_ena && (slot.w_reg_dst == src);
    endfunction

    // newest producer wins, slot 2 is younger than slot 1.
    function automatic fwd_sel_e pick_fwd(
        input logic [`BYPASS_REG_W-1:0] src,
        input slot_info_t               ex_1,
        input slot_info_t               ex_2,
        input slot_info_t               mem_1,
        input slot_info_t               mem_2
    );
        logic hit_ex_2;
        logic hit_ex_1;
        logic hit_mem_2;
        logic hit_mem_1;

        hit_ex_2  = reg_hit(src, ex_2);
        hit_ex_1  = reg_hit(src, ex_1);
        hit_mem_2 = reg_hit(src, mem_2);
        hit_mem_1 = reg_hit(src, mem_1);

        if (hit_ex_2) begin
            pick_fwd = FWD_EXP_ALU;
        end else if (hit_ex_1) begin
            pick_fwd = FWD_EXC_ALU;
        end else if (hit_mem_2 && mem_2.ls_ena) begin
            pick_fwd = FWD_MEMP_MEM;
        end else if (hit_mem_2) begin
            pick_fwd = FWD_MEMP_ALU;
        end else if (hit_mem_1 && mem_1.ls_ena) begin
            pick_fwd = FWD_MEMC_MEM;
        end else if (hit_mem_1) begin
            pick_fwd = FWD_MEMC_ALU;
        end else begin
            pick_fwd = FWD_NOP;
        end
    endfunction

    // hi/lo only come from the mem stage.
    function automatic hilo_sel_e pick_hilo(
        input logic wr_memp,
        input logic wr_memc
    );
        if (wr_memp) begin
            pick_hilo = HILO_MEMP;
        end else if (wr_memc) begin
            pick_hilo = HILO_MEMC;
        end else begin
            pick_hilo = HILO_NOP;
        end
    endfunction

    always_comb begin
        fwd_sel.rs = pick_fwd(id_rs, ex_slot_1, ex_slot_2, mem_slot_1, mem_slot_2);
        fwd_sel.rt = pick_fwd(id_rt, ex_slot_1, ex_slot_2, mem_slot_1, mem_slot_2);
        fwd_sel.hi = pick_hilo(mem_slot_2.w_hilo_ena[1], mem_slot_1.w_hilo_ena[1]);
        fwd_sel.lo = pick_hilo(mem_slot_2.w_hilo_ena[0], mem_slot_1.w_hilo_ena[0]);
    end

    // ==================================================
    // load-use hazard
    // ==================================================

    // load data is not ready until mem.
    assign ex_load_hit_1 = ex_slot_1.ls_ena &&
                           (reg_hit(id_rs, ex_slot_1) || reg_hit(id_rt, ex_slot_1));
    assign ex_load_hit_2 = ex_slot_2.ls_ena &&
                           (reg_hit(id_rs, ex_slot_2) || reg_hit(id_rt, ex_slot_2));

    assign stall_req = ex_load_hit_1 || ex_load_hit_2;
    assign flush_req = stall_req;

endmodule

// File: verification/bypass_assert.sv
`timescale 1ns/1ps

`include "bypass_defs.svh"

module bypass_assert (
    input logic                     clk,
    input logic                     arst_n,
    input logic [`BYPASS_REG_W-1:0] id_rs,
    input logic [`BYPASS_REG_W-1:0] id_rt,
    input bypass_pkg::slot_info_t   ex_slot_1,
    input bypass_pkg::slot_info_t   ex_slot_2,
    input bypass_pkg::slot_info_t   mem_slot_1,
    input bypass_pkg::slot_info_t   mem_slot_2,
    input bypass_pkg::fwd_sel_t     fwd_sel,
    input logic                     stall_req,
    input logic                     flush_req
);

    import bypass_pkg::*;

    logic load_hit_1;
    logic load_hit_2;

    assign load_hit_1 = ex_slot_1.w_reg_ena && ex_slot_1.ls_ena &&
                        (ex_slot_1.w_reg_dst == id_rs || ex_slot_1.w_reg_dst == id_rt);
    assign load_hit_2 = ex_slot_2.w_reg_ena && ex_slot_2.ls_ena &&
                        (ex_slot_2.w_reg_dst == id_rs || ex_slot_2.w_reg_dst == id_rt);

    stall_flush_equal: assert property (@(posedge clk) stall_req == flush_req)
        else $error("stall_req and flush_req differ");

    stall_needs_load: assert property (@(posedge clk) disable iff (!arst_n)
        stall_req |-> (load_hit_1 || load_hit_2))
        else $error("stall_req without a load match in execute");

    exp_sel_needs_write: assert property (@(posedge clk) disable iff (!arst_n)
        (fwd_sel.rs == FWD_EXP_ALU || fwd_sel.rt == FWD_EXP_ALU) |-> ex_slot_2.w_reg_ena)
        else $error("execute slot 2 selected but it does not write");

    // =================================================
    mem_idle_in_reset: assert property (@(posedge clk) !arst_n |->
        !(mem_slot_1.w_reg_ena || mem_slot_1.ls_ena || (|mem_slot_1.w_hilo_ena) ||
          mem_slot_2.w_reg_ena || mem_slot_2.ls_ena || (|mem_slot_2.w_hilo_ena)))
        else $error("mem stage enable set during reset");

endmodule

bind bypass_top bypass_assert u_bypass_assert (.*);

// File: verification/bypass_input.txt
# name rs rt, slot1 wen dst ld hilo alu hi lo, slot2 wen dst ld hilo alu hi lo
# ld1 ld2 rf_rs rf_rt rf_hi rf_lo, expected rs rt hi lo stall (all hex)
reset_idle 3 5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 10 11 12 13 10 11 12 13 0
ex_both 3 5 1 3 0 0 21 0 0 1 3 0 0 22 0 0 0 0 10 11 12 13 22 11 12 13 0
ex_slot1 3 5 1 5 0 0 31 0 0 1 7 0 0 32 0 0 0 0 10 11 12 13 22 31 12 13 0
mem_alu 7 5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 10 11 12 13 32 31 12 13 0
ex_load 3 5 1 3 1 0 41 0 0 1 5 1 0 42 0 0 0 0 10 11 12 13 41 42 12 13 1
mem_load 3 5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 51 52 10 11 12 13 51 52 12 13 0
ex_load_other 9 9 1 3 1 0 0 0 0 1 3 1 0 0 0 0 0 0 10 11 12 13 10 11 12 13 0
mem_load_prio 3 6 1 6 0 0 71 0 0 0 0 0 0 0 0 0 61 62 10 11 12 13 62 71 12 13 0
hilo_issue 1 2 0 0 0 3 0 81 82 0 0 0 2 0 91 92 0 0 10 11 12 13 10 11 12 13 0
hilo_mem 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 10 11 12 13 10 11 91 82 0
hilo_issue_2 1 2 0 0 0 2 0 a1 a2 0 0 0 1 0 b1 b2 0 0 14 15 16 17 14 15 16 17 0
hilo_split 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 14 15 16 17 14 15 a1 b2 0
idle_again 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 14 15 16 17 14 15 16 17 0
load_rt 4 8 1 8 1 0 e1 0 0 0 0 0 0 0 0 0 0 0 14 15 16 17 14 e1 16 17 1

// File: verification/bypass_tb.sv
`timescale 1ns/1ps

`include "bypass_defs.svh"

module bypass_tb;

    import bypass_pkg::*;

    localparam int NUM_COLS    = 27;
    localparam int CHECK_DELAY = 35;
    localparam int RESET_LIMIT = 20;
    localparam int LINE_LIMIT  = 64;

    logic                      clk;
    logic                      arst_n;
    logic [`BYPASS_REG_W-1:0]  id_rs;
    logic [`BYPASS_REG_W-1:0]  id_rt;
    slot_info_t                ex_slot_1;
    slot_info_t                ex_slot_2;
    logic [`BYPASS_DATA_W-1:0] mem_load_data_1;
    logic [`BYPASS_DATA_W-1:0] mem_load_data_2;
    logic [`BYPASS_DATA_W-1:0] rf_rs_data;
    logic [`BYPASS_DATA_W-1:0] rf_rt_data;
    logic [`BYPASS_DATA_W-1:0] rf_hi;
    logic [`BYPASS_DATA_W-1:0] rf_lo;
    logic [`BYPASS_DATA_W-1:0] rs_data;
    logic [`BYPASS_DATA_W-1:0] rt_data;
    logic [`BYPASS_DATA_W-1:0] hi_data;
    logic [`BYPASS_DATA_W-1:0] lo_data;
    logic                      stall_req;
    logic                      flush_req;

    bypass_top u_bypass_top (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    initial begin
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input string sig,
                               input logic [`BYPASS_DATA_W-1:0] exp_val,
                               input logic [`BYPASS_DATA_W-1:0] act_val);
        assert (act_val === exp_val) else begin
            stop_run($sformatf("mismatch %s %s expected %h actual %h",
                               test, sig, exp_val, act_val));
        end
    endtask

    // each slot takes seven columns from base on.
    function automatic slot_info_t slot_from_cols(input logic [31:0] c [NUM_COLS],
                                                  input int base);
        slot_info_t s;
        s.w_reg_ena  = c[base][0];
        s.w_reg_dst  = c[base+1][`BYPASS_REG_W-1:0];
        s.ls_ena     = c[base+2][0];
        s.w_hilo_ena = c[base+3][1:0];
        s.alu_res    = c[base+4];
        s.hi         = c[base+5];
        s.lo         = c[base+6];
        return s;
    endfunction

    initial begin
        int          fd;
        int          code;
        int          wait_cnt;
        int          n_lines;
        string       name;
        string       rest;
        logic [31:0] col [NUM_COLS];

        arst_n          <= 1'b0;
        id_rs           = '0;
        id_rt           = '0;
        ex_slot_1       = '0;
        ex_slot_2       = '0;
        mem_load_data_1 = '0;
        mem_load_data_2 = '0;
        rf_rs_data      = '0;
        rf_rt_data      = '0;
        rf_hi           = '0;
        rf_lo           = '0;

        fd = $fopen("verification/bypass_input.txt", "r");
        if (fd == 0) begin
            stop_run("could not open verification/bypass_input.txt");
        end

        wait_cnt = 0;
        while (arst_n !== 1'b1 && wait_cnt < RESET_LIMIT) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (arst_n !== 1'b1) begin
            stop_run("reset was never released");
        end

        // one line per clock with outputs sampled just before the next edge.
        n_lines = 0;
        code = $fscanf(fd, "%s", name);
        while (code == 1 && n_lines < LINE_LIMIT) begin
            if (name[0] == "#") begin
                code = $fgets(rest, fd);
            end else begin
                for (int i = 0; i < NUM_COLS; i++) begin
                    code = $fscanf(fd, "%h", col[i]);
                end
                if (code != 1) begin
                    stop_run({"incomplete line in the input file at ", name});
                end
                @(posedge clk);
                id_rs           <= col[0][`BYPASS_REG_W-1:0];
                id_rt           <= col[1][`BYPASS_REG_W-1:0];
                ex_slot_1       <= slot_from_cols(col, 2);
                ex_slot_2       <= slot_from_cols(col, 9);
                mem_load_data_1 <= col[16];
                mem_load_data_2 <= col[17];
                rf_rs_data      <= col[18];
                rf_rt_data      <= col[19];
                rf_hi           <= col[20];
                rf_lo           <= col[21];
                #CHECK_DELAY;
                check_value(name, "rs_data", col[22], rs_data);
                check_value(name, "rt_data", col[23], rt_data);
                check_value(name, "hi_data", col[24], hi_data);
                check_value(name, "lo_data", col[25], lo_data);
                check_value(name, "stall_req", col[26], 32'(stall_req));
                check_value(name, "flush_req", col[26], 32'(flush_req));
                n_lines++;
            end
            code = $fscanf(fd, "%s", name);
        end
        $fclose(fd);

        if (n_lines == 0 || n_lines >= LINE_LIMIT) begin
            stop_run("input file held no test lines or too many of them");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule
